// ==== design/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Data path width.
`define CSR_XLEN 64

// Machine-mode CSR addresses.
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MTIME    12'hB00
`define CSR_ADDR_MTIMECMP 12'h7C0 // Custom slot.

// SXL/UXL = 2, MPP = machine.
`define CSR_MSTATUS_RESET 64'h0000_000A_0000_1800

// mcause codes.
`define CSR_CAUSE_ILLEGAL   64'd2
`define CSR_CAUSE_ECALL     64'd11
`define CSR_CAUSE_TIMER_IRQ 64'h8000_0000_0000_0007

`endif

// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // CSR ops follow the funct3 encoding.
    typedef enum logic [2:0] {
        OP_ECALL = 3'd0,
        OP_CSRRW = 3'd1,
        OP_CSRRS = 3'd2,
        OP_CSRRC = 3'd3,
        OP_MRET  = 3'd4
    } csr_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_EXEC = 2'd1,
        ST_RESP = 2'd2
    } seq_state_e;

    typedef enum logic [1:0] {
        ACT_NONE = 2'd0,
        ACT_CSR  = 2'd1,
        ACT_TRAP = 2'd2,
        ACT_RET  = 2'd3
    } csr_action_e;

endpackage

`default_nettype wire

// ==== design/csr_access_if.sv ====
`default_nettype none

`include "csr_consts.svh"

interface csr_access_if import csr_pkg::*; ();

    // Sequencer side, valid for one cycle.
    csr_action_e          action;
    csr_op_e              op;
    logic [11:0]          addr;
    logic [`CSR_XLEN-1:0] operand;
    logic [`CSR_XLEN-1:0] pc;
    logic [`CSR_XLEN-1:0] cause;

    // Register file side, combinational.
    logic [`CSR_XLEN-1:0] old_value;
    logic                 illegal;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;
    logic                 irq_enable; // mstatus.MIE.

    modport seq (
        output action, op, addr, operand, pc, cause,
        input  old_value, illegal, mtvec, mepc, irq_enable
    );

    modport regs (
        input  action, op, addr, operand, pc, cause,
        output old_value, illegal, mtvec, mepc, irq_enable
    );

endinterface

`default_nettype wire

// ==== design/timer_access_if.sv ====
`default_nettype none

`include "csr_consts.svh"

interface timer_access_if ();

    logic                 cmp_wen;
    logic [`CSR_XLEN-1:0] cmp_wdata;
    logic [`CSR_XLEN-1:0] mtime;
    logic [`CSR_XLEN-1:0] mtimecmp;

    modport regs (
        output cmp_wen, cmp_wdata,
        input  mtime, mtimecmp
    );

    modport timer (
        input  cmp_wen, cmp_wdata,
        output mtime, mtimecmp
    );

endinterface

`default_nettype wire

// ==== design/machine_timer.sv ====
`default_nettype none

`include "csr_consts.svh"

module machine_timer (
    input  wire             I_sys_clk,
    input  wire             I_rst,
    timer_access_if.timer   tmr,
    output logic            timer_pending
);

    logic [`CSR_XLEN-1:0] mtime_q;
    logic [`CSR_XLEN-1:0] mtimecmp_q;
    logic                 pending_q;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1; // Never fires until written.
        end else begin
            mtime_q <= mtime_q + `CSR_XLEN'(1);
            if (tmr.cmp_wen) begin
                mtimecmp_q <= tmr.cmp_wdata;
            end
        end
    end

    // Registered compare.
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign tmr.mtime     = mtime_q;
    assign tmr.mtimecmp  = mtimecmp_q;
    assign timer_pending = pending_q;

endmodule

`default_nettype wire

// ==== design/csr_regfile.sv ====
`default_nettype none

`include "csr_consts.svh"

module csr_regfile import csr_pkg::*; (
    input  wire           I_sys_clk,
    input  wire           I_rst,
    csr_access_if.regs    acc,
    timer_access_if.regs  tmr
);

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;

    logic [`CSR_XLEN-1:0] mstatus_q;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mepc_q;
    logic [`CSR_XLEN-1:0] mcause_q;
    logic [`CSR_XLEN-1:0] rd_value;
    logic [`CSR_XLEN-1:0] wr_value;
    logic                 addr_known;
    logic                 csr_wen;

    // Address decode and read mux.
    always_comb begin
        addr_known = 1'b1;
        case (acc.addr)
            `CSR_ADDR_MSTATUS:  rd_value = mstatus_q;
            `CSR_ADDR_MTVEC:    rd_value = mtvec_q;
            `CSR_ADDR_MSCRATCH: rd_value = mscratch_q;
            `CSR_ADDR_MEPC:     rd_value = mepc_q;
            `CSR_ADDR_MCAUSE:   rd_value = mcause_q;
            `CSR_ADDR_MTIME:    rd_value = tmr.mtime;
            `CSR_ADDR_MTIMECMP: rd_value = tmr.mtimecmp;
            default: begin
                rd_value   = '0;
                addr_known = 1'b0;
            end
        endcase
    end

    // mtime is read only, so a plain write to it is illegal.
    assign acc.illegal = !addr_known ||
                         (acc.addr == `CSR_ADDR_MTIME && acc.op == OP_CSRRW);

    always_comb begin
        case (acc.op)
            OP_CSRRW: wr_value = acc.operand;
            OP_CSRRS: wr_value = rd_value | acc.operand;
            OP_CSRRC: wr_value = rd_value & ~acc.operand;
            default:  wr_value = rd_value;
        endcase
    end

    assign csr_wen = (acc.action == ACT_CSR);

    assign acc.old_value  = rd_value;
    assign acc.mtvec      = mtvec_q;
    assign acc.mepc       = mepc_q;
    assign acc.irq_enable = mstatus_q[MIE_BIT];

    // mtimecmp lives in the timer.
    assign tmr.cmp_wen   = csr_wen && (acc.addr == `CSR_ADDR_MTIMECMP);
    assign tmr.cmp_wdata = wr_value;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mstatus_q  <= `CSR_MSTATUS_RESET;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else begin
            case (acc.action)
                ACT_CSR: begin
                    case (acc.addr)
                        `CSR_ADDR_MSTATUS:  mstatus_q  <= wr_value;
                        `CSR_ADDR_MTVEC:    mtvec_q    <= wr_value;
                        `CSR_ADDR_MSCRATCH: mscratch_q <= wr_value;
                        `CSR_ADDR_MEPC:     mepc_q     <= wr_value;
                        `CSR_ADDR_MCAUSE:   mcause_q   <= wr_value;
                        default: ;
                    endcase
                end
                ACT_TRAP: begin
                    mepc_q               <= acc.pc;
                    mcause_q             <= acc.cause;
                    mstatus_q[MPIE_BIT]  <= mstatus_q[MIE_BIT];
                    mstatus_q[MIE_BIT]   <= 1'b0; // Interrupts off in handler.
                end
                ACT_RET: begin
                    mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
                    mstatus_q[MPIE_BIT] <= 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_sequencer.sv ====
`default_nettype none

`include "csr_consts.svh"

module csr_sequencer import csr_pkg::*; (
    input  wire                       I_sys_clk,
    input  wire                       I_rst,
    input  wire                       req_valid,
    input  wire csr_op_e              req_op,
    input  wire [11:0]                req_addr,
    input  wire [`CSR_XLEN-1:0]       req_wdata,
    input  wire [`CSR_XLEN-1:0]       req_pc,
    output logic                      req_ready,
    output logic                      resp_valid,
    output logic [`CSR_XLEN-1:0]      resp_data,
    output logic                      resp_redirect,
    input  wire                       resp_ready,
    input  wire                       timer_pending,
    csr_access_if.seq                 acc
);

    seq_state_e           state_q;
    csr_op_e              op_q;
    logic [11:0]          addr_q;
    logic [`CSR_XLEN-1:0] wdata_q;
    logic [`CSR_XLEN-1:0] pc_q;
    logic                 irq_q;
    logic [`CSR_XLEN-1:0] resp_data_q;
    logic                 resp_redirect_q;
    logic                 accept;

    assign req_ready     = (state_q == ST_IDLE);
    assign accept        = req_valid && req_ready;
    assign resp_valid    = (state_q == ST_RESP);
    assign resp_data     = resp_data_q;
    assign resp_redirect = resp_redirect_q;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_EXEC;
                    end
                end
                ST_EXEC: state_q <= ST_RESP; // Always one cycle.
                ST_RESP: begin
                    if (resp_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Request latch. An enabled pending timer preempts the request.
    always_ff @(posedge I_sys_clk) begin
        if (accept) begin
            op_q    <= req_op;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            pc_q    <= req_pc;
            irq_q   <= timer_pending && acc.irq_enable;
        end
    end

    assign acc.op      = op_q;
    assign acc.addr    = addr_q;
    assign acc.operand = wdata_q;
    assign acc.pc      = pc_q;

    always_comb begin
        acc.action = ACT_NONE;
        acc.cause  = '0;
        if (state_q == ST_EXEC) begin
            if (irq_q) begin
                acc.action = ACT_TRAP;
                acc.cause  = `CSR_CAUSE_TIMER_IRQ;
            end else if (op_q == OP_ECALL) begin
                acc.action = ACT_TRAP;
                acc.cause  = `CSR_CAUSE_ECALL;
            end else if (op_q == OP_MRET) begin
                acc.action = ACT_RET;
            end else if (acc.illegal) begin
                // Bad access traps, nothing written.
                acc.action = ACT_TRAP;
                acc.cause  = `CSR_CAUSE_ILLEGAL;
            end else begin
                acc.action = ACT_CSR;
            end
        end
    end

    // Response held until taken.
    always_ff @(posedge I_sys_clk) begin
        if (state_q == ST_EXEC) begin
            case (acc.action)
                ACT_TRAP: resp_data_q <= acc.mtvec;
                ACT_RET:  resp_data_q <= acc.mepc;
                default:  resp_data_q <= acc.old_value;
            endcase
            resp_redirect_q <= (acc.action != ACT_CSR);
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_unit.sv ====
`default_nettype none

`include "csr_consts.svh"

module csr_unit import csr_pkg::*; (
    input  wire                   I_sys_clk,
    input  wire                   I_rst,

    // Request.
    input  wire                   req_valid,
    output logic                  req_ready,
    input  wire csr_op_e          req_op,
    input  wire [11:0]            req_addr,
    input  wire [`CSR_XLEN-1:0]   req_wdata,
    input  wire [`CSR_XLEN-1:0]   req_pc,

    // Response.
    output logic                  resp_valid,
    input  wire                   resp_ready,
    output logic [`CSR_XLEN-1:0]  resp_data,
    output logic                  resp_redirect
);

    logic timer_pending;

    csr_access_if   acc_if ();
    timer_access_if tmr_if ();

    csr_sequencer u_sequencer (
        .I_sys_clk     (I_sys_clk),
        .I_rst         (I_rst),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_pc        (req_pc),
        .req_ready     (req_ready),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .resp_redirect (resp_redirect),
        .resp_ready    (resp_ready),
        .timer_pending (timer_pending),
        .acc           (acc_if.seq)
    );

    csr_regfile u_regfile (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .acc       (acc_if.regs),
        .tmr       (tmr_if.regs)
    );

    machine_timer u_timer (
        .I_sys_clk     (I_sys_clk),
        .I_rst         (I_rst),
        .tmr           (tmr_if.timer),
        .timer_pending (timer_pending)
    );

endmodule

`default_nettype wire

// ==== tests/csr_unit_assertions.sv ====
`default_nettype none

`include "csr_consts.svh"

module csr_unit_assertions (
    input wire                 I_sys_clk,
    input wire                 I_rst,
    input wire                 req_ready,
    input wire                 resp_valid,
    input wire                 resp_ready,
    input wire [`CSR_XLEN-1:0] resp_data,
    input wire                 resp_redirect
);

    // A stalled response must hold.
    resp_hold: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data) && $stable(resp_redirect))
        else $error("response changed while resp_ready was low");

    one_in_flight: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        !(req_ready && resp_valid))
        else $error("req_ready and resp_valid high together");

    reset_clears: assert property (@(posedge I_sys_clk) I_rst |=> !resp_valid)
        else $error("resp_valid high right after reset");

endmodule

bind csr_unit csr_unit_assertions u_assertions (
    .I_sys_clk     (I_sys_clk),
    .I_rst         (I_rst),
    .req_ready     (req_ready),
    .resp_valid    (resp_valid),
    .resp_ready    (resp_ready),
    .resp_data     (resp_data),
    .resp_redirect (resp_redirect)
);

`default_nettype wire

// ==== tests/tb_csr_unit.sv ====
`default_nettype none

`include "csr_consts.svh"

module tb_csr_unit import csr_pkg::*; ();

    localparam int PERIOD   = 4;
    localparam int MAX_REQS = 200; // Bound on requests over all tests.
    localparam int REQ_CYC  = 10;  // Worst case cycles per request.
    localparam int MARGIN   = 2;

    logic                 I_sys_clk = 1'b0;
    logic                 I_rst;
    logic                 req_valid;
    logic                 req_ready;
    csr_op_e              req_op;
    logic [11:0]          req_addr;
    logic [`CSR_XLEN-1:0] req_wdata;
    logic [`CSR_XLEN-1:0] req_pc;
    logic                 resp_valid;
    logic                 resp_ready;
    logic [`CSR_XLEN-1:0] resp_data;
    logic                 resp_redirect;

    integer               seed = 56860;
    logic [`CSR_XLEN-1:0] mstatus_m; // Reference model.
    logic [`CSR_XLEN-1:0] mtvec_m;
    logic [`CSR_XLEN-1:0] mscratch_m;

    csr_unit dut0 (.*);

    always #(PERIOD / 2) I_sys_clk = ~I_sys_clk;

    initial begin
        #(MAX_REQS * REQ_CYC * MARGIN * PERIOD);
        $display("Timeout: the tests did not complete in the expected time");
        $display("Verification failed");
        $fatal(1);
    end

    task automatic check_val(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        if (act !== exp) begin
            $display("** Error at time %0t: %s expected %h, actual %h", $time, name, exp, act);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    function automatic logic [63:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // MPIE takes MIE, MIE cleared.
    function automatic logic [63:0] status_after_trap(input logic [63:0] s);
        logic [63:0] r;
        r    = s;
        r[7] = s[3];
        r[3] = 1'b0;
        return r;
    endfunction

    function automatic logic [63:0] status_after_ret(input logic [63:0] s);
        logic [63:0] r;
        r    = s;
        r[3] = s[7];
        r[7] = 1'b1;
        return r;
    endfunction

    task automatic do_req(input csr_op_e op, input logic [11:0] addr,
                          input logic [63:0] wdata, input logic [63:0] pc);
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_pc    = pc;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(posedge I_sys_clk);
            #1;
        end
        @(posedge I_sys_clk); // Accepted.
        #1;
        req_valid = 1'b0;
    endtask

    task automatic get_resp(input int stall, output logic [63:0] data, output logic redir);
        int waited;
        waited = 0;
        while (!resp_valid) begin
            @(posedge I_sys_clk);
            #1;
            waited++;
        end
        check_val("resp_valid latency", 64'd1, 64'(waited));
        repeat (stall) begin
            @(posedge I_sys_clk);
            #1;
        end
        data       = resp_data;
        redir      = resp_redirect;
        resp_ready = 1'b1;
        @(posedge I_sys_clk);
        #1;
        resp_ready = 1'b0;
        check_val("req_ready after response", 64'd1, 64'(req_ready));
    endtask

    task automatic access(input csr_op_e op, input logic [11:0] addr,
                          input logic [63:0] wdata, input logic [63:0] pc, input int stall,
                          output logic [63:0] data, output logic redir);
        do_req(op, addr, wdata, pc);
        get_resp(stall, data, redir);
    endtask

    // Plain CSR op, expects the old value back.
    task automatic op_check(input csr_op_e op, input logic [11:0] addr, input logic [63:0] wdata,
                            input int stall, input logic [63:0] exp_old, input string name);
        logic [63:0] data;
        logic        redir;
        access(op, addr, wdata, 64'h100, stall, data, redir);
        check_val(name, exp_old, data);
        check_val({name, " redirect"}, 64'd0, 64'(redir));
    endtask

    task automatic read_check(input logic [11:0] addr, input string name,
                              input logic [63:0] exp);
        op_check(OP_CSRRS, addr, 64'd0, 0, exp, name);
    endtask

    task automatic trap_check(input csr_op_e op, input logic [11:0] addr, input logic [63:0] wdata,
                              input logic [63:0] pc, input logic [63:0] cause,
                              input string name);
        logic [63:0] data;
        logic        redir;
        access(op, addr, wdata, pc, 0, data, redir);
        check_val({name, " data"}, mtvec_m, data);
        check_val({name, " redirect"}, 64'd1, 64'(redir));
        mstatus_m = status_after_trap(mstatus_m);
        read_check(`CSR_ADDR_MEPC, {name, " mepc"}, pc);
        read_check(`CSR_ADDR_MCAUSE, {name, " mcause"}, cause);
        read_check(`CSR_ADDR_MSTATUS, {name, " mstatus"}, mstatus_m);
    endtask

    task automatic test_reset_values();
        read_check(`CSR_ADDR_MSTATUS, "mstatus", `CSR_MSTATUS_RESET);
        read_check(`CSR_ADDR_MTVEC, "mtvec", 64'd0);
        read_check(`CSR_ADDR_MSCRATCH, "mscratch", 64'd0);
        read_check(`CSR_ADDR_MEPC, "mepc", 64'd0);
        read_check(`CSR_ADDR_MCAUSE, "mcause", 64'd0);
        read_check(`CSR_ADDR_MTIMECMP, "mtimecmp", '1);
    endtask

    task automatic test_rmw();
        logic [63:0] wdata;
        logic [63:0] model;
        logic [11:0] addr;
        csr_op_e     op;
        int          i;
        for (i = 0; i < 24; i++) begin
            addr  = (i % 2 == 1) ? `CSR_ADDR_MTVEC : `CSR_ADDR_MSCRATCH;
            model = (i % 2 == 1) ? mtvec_m : mscratch_m;
            wdata = rand_word();
            case ((i / 2) % 3)
                0: op = OP_CSRRW;
                1: op = OP_CSRRS;
                default: op = OP_CSRRC;
            endcase
            op_check(op, addr, wdata, $random(seed) & 3, model, "rmw old value");
            case (op)
                OP_CSRRW: model = wdata;
                OP_CSRRS: model = model | wdata;
                default:  model = model & ~wdata;
            endcase
            if (i % 2 == 1) mtvec_m = model;
            else mscratch_m = model;
            read_check(addr, "rmw new value", model);
        end
    endtask

    task automatic test_ecall_mret();
        logic [63:0] data;
        logic        redir;
        op_check(OP_CSRRS, `CSR_ADDR_MSTATUS, 64'h8, 0, mstatus_m, "set mie");
        mstatus_m = mstatus_m | 64'h8;
        op_check(OP_CSRRW, `CSR_ADDR_MTVEC, 64'h8000_0100, 0, mtvec_m, "mtvec setup");
        mtvec_m = 64'h8000_0100;
        trap_check(OP_ECALL, 12'h0, 64'd0, 64'h8000_2004, `CSR_CAUSE_ECALL, "ecall");
        access(OP_MRET, 12'h0, 64'd0, 64'h8000_0104, 0, data, redir);
        check_val("mret data", 64'h8000_2004, data);
        check_val("mret redirect", 64'd1, 64'(redir));
        mstatus_m = status_after_ret(mstatus_m);
        read_check(`CSR_ADDR_MSTATUS, "mstatus after mret", mstatus_m);
    endtask

    task automatic test_illegal();
        logic [63:0] t0;
        logic [63:0] t1;
        logic        redir;
        trap_check(OP_CSRRW, 12'h123, 64'hDEAD, 64'h3000, `CSR_CAUSE_ILLEGAL, "unknown csr");
        access(OP_CSRRS, `CSR_ADDR_MTIME, 64'd0, 64'h3004, 0, t0, redir);
        trap_check(OP_CSRRW, `CSR_ADDR_MTIME, 64'hFFFF_0000_0000_0000, 64'h3008,
                   `CSR_CAUSE_ILLEGAL, "mtime write");
        access(OP_CSRRS, `CSR_ADDR_MTIME, 64'd0, 64'h300C, 0, t1, redir);
        check_val("mtime unchanged by write", 64'd1, 64'(t1 > t0 && t1 - t0 < 64'd100));
    endtask

    task automatic test_timer_irq();
        logic [63:0] t0;
        logic [63:0] t1;
        logic [63:0] t2;
        logic [63:0] data;
        logic [63:0] pc;
        logic        redir;
        int          i;
        op_check(OP_CSRRS, `CSR_ADDR_MSTATUS, 64'h8, 0, mstatus_m, "set mie");
        mstatus_m = mstatus_m | 64'h8;
        access(OP_CSRRS, `CSR_ADDR_MTIME, 64'd0, 64'h4000, 0, t0, redir);
        access(OP_CSRRS, `CSR_ADDR_MTIME, 64'd0, 64'h4004, 0, t1, redir);
        access(OP_CSRRS, `CSR_ADDR_MTIME, 64'd0, 64'h4008, 0, t2, redir);
        check_val("mtime increasing", 64'd1, 64'(t1 > t0 && t2 > t1));
        op_check(OP_CSRRW, `CSR_ADDR_MTIMECMP, t2 + 64'd200, 0, '1, "mtimecmp write");
        read_check(`CSR_ADDR_MSCRATCH, "mscratch before irq", mscratch_m);
        i     = 0;
        redir = 1'b0;
        while (!redir && i < 120) begin
            pc = 64'h5000 + 64'(4 * i);
            access(OP_CSRRW, `CSR_ADDR_MSCRATCH, 64'hC0DE_0000 + 64'(i), pc, 0, data, redir);
            if (!redir) begin
                check_val("mscratch old", mscratch_m, data);
                mscratch_m = 64'hC0DE_0000 + 64'(i);
            end
            i++;
        end
        if (!redir) begin
            $display("The timer interrupt was never taken");
            $display("Verification failed");
            $fatal(1);
        end
        check_val("irq data", mtvec_m, data);
        mstatus_m = status_after_trap(mstatus_m);
        read_check(`CSR_ADDR_MCAUSE, "irq mcause", `CSR_CAUSE_TIMER_IRQ);
        read_check(`CSR_ADDR_MEPC, "irq mepc", pc);
        read_check(`CSR_ADDR_MSTATUS, "irq mstatus", mstatus_m);
        read_check(`CSR_ADDR_MSCRATCH, "mscratch after irq", mscratch_m); // Request dropped.
    endtask

    initial begin
        I_rst      = 1'b1;
        req_valid  = 1'b0;
        req_op     = OP_CSRRS;
        req_addr   = '0;
        req_wdata  = '0;
        req_pc     = '0;
        resp_ready = 1'b0;
        mstatus_m  = `CSR_MSTATUS_RESET;
        mtvec_m    = '0;
        mscratch_m = '0;
        repeat (4) @(posedge I_sys_clk);
        #1;
        I_rst = 1'b0;
        test_reset_values();
        test_rmw();
        test_ecall_mret();
        test_illegal();
        test_timer_irq();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/csr_pkg.sv
design/csr_access_if.sv
design/timer_access_if.sv
design/machine_timer.sv
design/csr_regfile.sv
design/csr_sequencer.sv
design/csr_unit.sv
tests/csr_unit_assertions.sv
tests/tb_csr_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
